// File: design/csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [6:0]  ecode_t;

    // CSR numbers handled by the file
    localparam csr_addr_t CSR_CRMD   = 14'h0000;
    localparam csr_addr_t CSR_PRMD   = 14'h0001;
    localparam csr_addr_t CSR_ESTAT  = 14'h0005;
    localparam csr_addr_t CSR_ERA    = 14'h0006;
    localparam csr_addr_t CSR_BADV   = 14'h0007;
    localparam csr_addr_t CSR_EENTRY = 14'h000c;
    localparam csr_addr_t CSR_SAVE0  = 14'h0030;

    // Exceptions that also record BADV
    localparam ecode_t ECODE_ADEF = 7'h08; // Fetch address error
    localparam ecode_t ECODE_ALE  = 7'h09; // Misaligned load/store

    // CRMD layout; PRMD keeps pplv/pie at the same bits
    typedef struct packed {
        logic [28:0] rsvd;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    // ESTAT layout
    typedef struct packed {
        logic [8:0]  hi;
        ecode_t      ecode;    // Bits 22:16
        logic [15:0] lo;
    } estat_t;

endpackage

// File: design/pipe_pkg.sv
package pipe_pkg;

    import csr_pkg::*;

    // Exception info of one issue slot
    typedef struct packed {
        ecode_t      ecode;
        logic        exc;
        logic [31:0] badv;
        logic        badv_we;
        logic [31:0] pc;
    } slot_exc_t;

    // What EX hands over each cycle, held as is in MEM
    typedef struct packed {
        csr_addr_t   waddr;
        logic [31:0] wmask;
        logic [31:0] wdata;
        logic        ertn;
        slot_exc_t   slot_a;   // Older slot
        slot_exc_t   slot_b;
        logic        valid;
    } ex_csr_t;

    // Resolved MEM result, committed from WB
    typedef struct packed {
        csr_addr_t   waddr;
        logic [31:0] wmask;
        logic [31:0] wdata;
        logic        ertn;
        ecode_t      ecode;
        logic        exc;      // Exception entry, save CRMD
        logic [31:0] badv;
        logic        badv_we;
        logic [31:0] era;
        logic        flush;
        logic [31:0] flush_pc;
    } wb_csr_t;

endpackage

// File: design/csr_pipe_reg.sv
`timescale 1ns/1ps

module csr_pipe_reg import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall_dcache,
    input  logic    stall_div,
    input  logic    br_a,
    input  ex_csr_t ex_in,
    input  wb_csr_t mem_wb,
    output ex_csr_t mem_bundle,
    output wb_csr_t wb_bundle,
    output logic    wb_commit
);

    logic advance;
    logic wb_valid;
    logic kill_all;

    // Either stall source freezes both stages
    assign advance   = !stall_dcache && !stall_div;
    assign wb_commit = wb_valid && advance;

    // A flush leaving WB discards everything younger
    assign kill_all  = wb_commit && wb_bundle.flush;

    // EX -> MEM
    always_ff @(posedge clk) begin
        if (rst || kill_all) begin
            mem_bundle <= '0;
        end else if (advance) begin
            if (br_a) begin
                mem_bundle <= '0; // Slot A mispredicted
            end else begin
                mem_bundle <= ex_in;
            end
        end
    end

    // MEM -> WB
    always_ff @(posedge clk) begin
        if (rst || kill_all) begin
            wb_bundle <= '0;
            wb_valid  <= 1'b0;
        end else if (advance) begin
            wb_bundle <= mem_wb;
            wb_valid  <= mem_bundle.valid;
        end
    end

endmodule

// File: design/csr_exc_select.sv
`timescale 1ns/1ps

module csr_exc_select import pipe_pkg::*; (
    input  ex_csr_t     mem_bundle,
    input  logic [31:0] eentry,
    input  logic [31:0] era,
    output wb_csr_t     mem_wb
);

    slot_exc_t win;
    logic      exc_a;
    logic      exc_b;
    logic      any_exc;
    logic      do_ertn;
    logic      do_write;

    assign exc_a   = mem_bundle.valid && mem_bundle.slot_a.exc;
    assign exc_b   = mem_bundle.valid && mem_bundle.slot_b.exc;
    assign any_exc = exc_a || exc_b;

    // Older slot wins
    assign win = exc_a ? mem_bundle.slot_a : mem_bundle.slot_b;

    // An exception cancels the CSR write and ertn
    assign do_ertn  = mem_bundle.valid && mem_bundle.ertn && !any_exc;
    assign do_write = mem_bundle.valid && !any_exc && (mem_bundle.wmask != 32'h0);

    always_comb begin
        mem_wb       = '0;
        mem_wb.waddr = mem_bundle.waddr;
        mem_wb.wdata = mem_bundle.wdata;
        mem_wb.wmask = do_write ? mem_bundle.wmask : 32'h0;
        mem_wb.ertn  = do_ertn;

        if (any_exc) begin
            mem_wb.exc      = 1'b1;
            mem_wb.ecode    = win.ecode;
            mem_wb.era      = win.pc;
            mem_wb.badv     = win.badv;
            mem_wb.badv_we  = win.badv_we;
            mem_wb.flush    = 1'b1;
            mem_wb.flush_pc = eentry;
        end else if (do_ertn) begin
            mem_wb.flush    = 1'b1;
            mem_wb.flush_pc = era;
        end else if (do_write) begin
            // Refetch after the CSR instruction
            mem_wb.flush    = 1'b1;
            mem_wb.flush_pc = mem_bundle.slot_a.pc + 32'd4;
        end
    end

endmodule

// File: design/csr_file.sv
`timescale 1ns/1ps

module csr_file import csr_pkg::*, pipe_pkg::*; #(
    parameter logic [31:0] EENTRY_RESET = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  wb_csr_t     wb_bundle,
    input  logic        wb_commit,
    input  csr_addr_t   csr_raddr,
    output logic [31:0] csr_rdata,
    output logic [31:0] eentry,
    output logic [31:0] era
);

    crmd_t       crmd;
    crmd_t       prmd;     // pplv/pie share CRMD bit positions
    estat_t      estat;
    logic [31:0] badv;
    logic [31:0] save0;
    logic [31:0] wmask;
    logic [31:0] wdata;

    assign wmask = wb_bundle.wmask;
    assign wdata = wb_bundle.wdata;

    function automatic logic [31:0] merge(
        input logic [31:0] old,
        input logic [31:0] mask,
        input logic [31:0] data
    );
        return (old & ~mask) | (data & mask);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd   <= '0;
            prmd   <= '0;
            estat  <= '0;
            era    <= 32'h0;
            badv   <= 32'h0;
            eentry <= EENTRY_RESET;
            save0  <= 32'h0;
        end else if (wb_commit) begin
            // Masked write, unlisted numbers fall through
            case (wb_bundle.waddr)
                CSR_CRMD:   crmd   <= merge(crmd, wmask, wdata);
                CSR_PRMD:   prmd   <= merge(prmd, wmask, wdata);
                CSR_ESTAT:  estat  <= merge(estat, wmask, wdata);
                CSR_ERA:    era    <= merge(era, wmask, wdata);
                CSR_BADV:   badv   <= merge(badv, wmask, wdata);
                CSR_EENTRY: eentry <= merge(eentry, wmask, wdata);
                CSR_SAVE0:  save0  <= merge(save0, wmask, wdata);
                default: ;
            endcase

            if (wb_bundle.exc) begin
                // Save state, drop to PLV0 with interrupts off
                prmd.plv    <= crmd.plv;
                prmd.ie     <= crmd.ie;
                crmd.plv    <= 2'b00;
                crmd.ie     <= 1'b0;
                estat.ecode <= wb_bundle.ecode;
                era         <= wb_bundle.era;
                if (wb_bundle.badv_we) begin
                    badv <= wb_bundle.badv;
                end
            end else if (wb_bundle.ertn) begin
                crmd.plv <= prmd.plv; // Restore, overrides a same-bundle write
                crmd.ie  <= prmd.ie;
            end
        end
    end

    always_comb begin
        case (csr_raddr)
            CSR_CRMD:   csr_rdata = crmd;
            CSR_PRMD:   csr_rdata = prmd;
            CSR_ESTAT:  csr_rdata = estat;
            CSR_ERA:    csr_rdata = era;
            CSR_BADV:   csr_rdata = badv;
            CSR_EENTRY: csr_rdata = eentry;
            CSR_SAVE0:  csr_rdata = save0;
            default:    csr_rdata = 32'h0;
        endcase
    end

endmodule

// File: design/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top import csr_pkg::*, pipe_pkg::*; #(
    parameter logic [31:0] EENTRY_RESET = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall_dcache,
    input  logic        stall_div,
    input  logic        br_a,
    input  ex_csr_t     ex_in,
    input  csr_addr_t   csr_raddr,
    output logic [31:0] csr_rdata,
    output logic        flush,
    output logic [31:0] flush_pc
);

    ex_csr_t     mem_bundle;
    wb_csr_t     mem_wb;
    wb_csr_t     wb_bundle;
    logic        wb_commit;
    logic [31:0] eentry;
    logic [31:0] era;

    csr_pipe_reg i_pipe_reg (
        .clk          (clk),
        .rst          (rst),
        .stall_dcache (stall_dcache),
        .stall_div    (stall_div),
        .br_a         (br_a),
        .ex_in        (ex_in),
        .mem_wb       (mem_wb),
        .mem_bundle   (mem_bundle),
        .wb_bundle    (wb_bundle),
        .wb_commit    (wb_commit)
    );

    csr_exc_select i_exc_select (
        .mem_bundle (mem_bundle),
        .eentry     (eentry),
        .era        (era),
        .mem_wb     (mem_wb)
    );

    csr_file #(
        .EENTRY_RESET (EENTRY_RESET)
    ) i_csr_file (
        .clk       (clk),
        .rst       (rst),
        .wb_bundle (wb_bundle),
        .wb_commit (wb_commit),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata),
        .eentry    (eentry),
        .era       (era)
    );

    // Redirect only while the flushing bundle commits
    assign flush    = wb_commit && wb_bundle.flush;
    assign flush_pc = flush ? wb_bundle.flush_pc : 32'h0;

endmodule

// File: bench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*, pipe_pkg::*; ();

    localparam logic [31:0] EENTRY_RESET = 32'h1c00_4000;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES   = 3000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_CYCLES + 2 * 8;
    localparam int TIMEOUT_NS   = TOTAL_CYCLES * CLK_PERIOD * 2;

    logic        clk;
    logic        rst;
    logic        stall_dcache;
    logic        stall_div;
    logic        br_a;
    ex_csr_t     ex_in;
    csr_addr_t   csr_raddr;
    logic [31:0] csr_rdata;
    logic        flush;
    logic [31:0] flush_pc;

    logic [31:0] lfsr;
    csr_addr_t   addr_list [0:7];

    // Reference model state
    ex_csr_t     m_mem;
    wb_csr_t     m_wb;
    logic        m_wb_valid;
    crmd_t       m_crmd;
    crmd_t       m_prmd;
    logic [31:0] m_estat;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_save0;

    int n_exc;
    int n_ertn;
    int n_write;
    int n_br_kill;
    int n_flush_kill;

    csr_unit_top #(
        .EENTRY_RESET (EENTRY_RESET)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .stall_dcache (stall_dcache),
        .stall_div    (stall_div),
        .br_a         (br_a),
        .ex_in        (ex_in),
        .csr_raddr    (csr_raddr),
        .csr_rdata    (csr_rdata),
        .flush        (flush),
        .flush_pc     (flush_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog expired before the test finished");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic csr_addr_t pick_addr();
        logic [31:0] r;
        r = lfsr_bits(3);
        return addr_list[r[2:0]];
    endfunction

    function automatic slot_exc_t random_slot(input int exc_bits);
        slot_exc_t   s;
        logic [31:0] r;
        s.exc = (lfsr_bits(exc_bits) == 32'd0); // 1 in 2**exc_bits
        r = lfsr_bits(2);
        case (r[1:0])
            2'd0: s.ecode = ECODE_ADEF;
            2'd1: s.ecode = ECODE_ALE;
            default: begin
                r = lfsr_bits(7);
                s.ecode = r[6:0];
            end
        endcase
        s.badv_we = (s.ecode == ECODE_ADEF) || (s.ecode == ECODE_ALE);
        s.badv    = lfsr_bits(32);
        r = lfsr_bits(30);
        s.pc = {r[29:0], 2'b00};
        return s;
    endfunction

    function automatic logic [31:0] write_bits(
        input logic [31:0] old,
        input logic [31:0] mask,
        input logic [31:0] data
    );
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            w[i] = mask[i] ? data[i] : old[i];
        end
        return w;
    endfunction

    // What MEM should hand to WB for one bundle
    function automatic wb_csr_t resolve(
        input ex_csr_t     b,
        input logic [31:0] ent,
        input logic [31:0] ret
    );
        wb_csr_t   r;
        slot_exc_t s;
        r = '0;
        if (b.valid && (b.slot_a.exc || b.slot_b.exc)) begin
            s = b.slot_a.exc ? b.slot_a : b.slot_b;
            r.exc      = 1'b1;
            r.ecode    = s.ecode;
            r.era      = s.pc;
            r.badv     = s.badv;
            r.badv_we  = s.badv_we;
            r.flush    = 1'b1;
            r.flush_pc = ent;
        end else if (b.valid) begin
            r.waddr = b.waddr;
            r.wmask = b.wmask;
            r.wdata = b.wdata;
            r.ertn  = b.ertn;
            if (b.ertn) begin
                r.flush    = 1'b1;
                r.flush_pc = ret;
            end else if (b.wmask != 32'h0) begin
                r.flush    = 1'b1;
                r.flush_pc = b.slot_a.pc + 32'd4;
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] read_model(input csr_addr_t a);
        case (a)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ESTAT:  return m_estat;
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save0;
            default:    return 32'h0;
        endcase
    endfunction

    task automatic reset_model();
        m_mem      = '0;
        m_wb       = '0;
        m_wb_valid = 1'b0;
        m_crmd     = '0;
        m_prmd     = '0;
        m_estat    = 32'h0;
        m_era      = 32'h0;
        m_badv     = 32'h0;
        m_eentry   = EENTRY_RESET;
        m_save0    = 32'h0;
    endtask

    task automatic commit_csr(input wb_csr_t w);
        crmd_t old_crmd;
        crmd_t old_prmd;
        old_crmd = m_crmd;
        old_prmd = m_prmd;
        case (w.waddr)
            CSR_CRMD:   m_crmd   = write_bits(m_crmd, w.wmask, w.wdata);
            CSR_PRMD:   m_prmd   = write_bits(m_prmd, w.wmask, w.wdata);
            CSR_ESTAT:  m_estat  = write_bits(m_estat, w.wmask, w.wdata);
            CSR_ERA:    m_era    = write_bits(m_era, w.wmask, w.wdata);
            CSR_BADV:   m_badv   = write_bits(m_badv, w.wmask, w.wdata);
            CSR_EENTRY: m_eentry = write_bits(m_eentry, w.wmask, w.wdata);
            CSR_SAVE0:  m_save0  = write_bits(m_save0, w.wmask, w.wdata);
            default: ;
        endcase
        if (w.wmask != 32'h0) n_write++;
        if (w.exc) begin
            n_exc++;
            m_prmd.plv = old_crmd.plv;
            m_prmd.ie  = old_crmd.ie;
            m_crmd.plv = 2'b00;
            m_crmd.ie  = 1'b0;
            m_estat[22:16] = w.ecode;
            m_era = w.era;
            if (w.badv_we) m_badv = w.badv;
        end else if (w.ertn) begin
            n_ertn++;
            m_crmd.plv = old_prmd.plv; // Old PRMD, even if written in this bundle
            m_crmd.ie  = old_prmd.ie;
        end
    endtask

    // One rising edge of the model, using the inputs now driven
    task automatic step_model();
        logic    advance;
        logic    commit;
        wb_csr_t next_wb;
        advance = !stall_dcache && !stall_div;
        commit  = m_wb_valid && advance;
        next_wb = resolve(m_mem, m_eentry, m_era);
        if (commit) commit_csr(m_wb);
        if (commit && m_wb.flush) begin
            if (m_mem.valid) n_flush_kill++;
            m_mem      = '0;
            m_wb       = '0;
            m_wb_valid = 1'b0;
        end else if (advance) begin
            m_wb       = next_wb;
            m_wb_valid = m_mem.valid;
            if (br_a) begin
                if (ex_in.valid) n_br_kill++;
                m_mem = '0;
            end else begin
                m_mem = ex_in;
            end
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_outputs();
        logic        exp_flush;
        logic [31:0] exp_pc;
        exp_flush = m_wb_valid && !stall_dcache && !stall_div && m_wb.flush;
        exp_pc    = exp_flush ? m_wb.flush_pc : 32'h0;
        compare("flush", {31'h0, flush}, {31'h0, exp_flush});
        compare("flush_pc", flush_pc, exp_pc);
        compare("csr_rdata", csr_rdata, read_model(csr_raddr));
    endtask

    task automatic drive_random();
        ex_csr_t b;
        b = '0;
        b.valid  = (lfsr_bits(2) != 32'd0);
        b.waddr  = pick_addr();
        b.wmask  = (lfsr_bits(1) != 32'd0) ? lfsr_bits(32) : 32'h0;
        b.wdata  = lfsr_bits(32);
        b.ertn   = (lfsr_bits(3) == 32'd0);
        b.slot_a = random_slot(4);
        b.slot_b = random_slot(3);
        ex_in        = b;
        br_a         = (lfsr_bits(4) == 32'd0);
        stall_dcache = (lfsr_bits(2) == 32'd0);
        stall_div    = (lfsr_bits(2) == 32'd0);
        csr_raddr    = pick_addr();
    endtask

    // Idle pipe, read back every address
    task automatic read_all();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            ex_in        = '0;
            br_a         = 1'b0;
            stall_dcache = 1'b0;
            stall_div    = 1'b0;
            csr_raddr    = addr_list[i];
            #1;
            check_outputs();
            step_model();
        end
    endtask

    initial begin
        rst          = 1'b1;
        stall_dcache = 1'b0;
        stall_div    = 1'b0;
        br_a         = 1'b0;
        ex_in        = '0;
        csr_raddr    = '0;
        lfsr         = 32'h798c;
        addr_list    = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA,
                         CSR_BADV, CSR_EENTRY, CSR_SAVE0, 14'h0002};
        n_exc        = 0;
        n_ertn       = 0;
        n_write      = 0;
        n_br_kill    = 0;
        n_flush_kill = 0;
        reset_model();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_all();
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk);
            drive_random();
            #1;
            check_outputs();
            step_model();
        end
        read_all(); // Drains the pipe too

        if (n_exc == 0 || n_ertn == 0 || n_write == 0 || n_br_kill == 0 || n_flush_kill == 0) begin
            $display("Error: some case was never exercised (exc %0d ertn %0d write %0d br %0d kill %0d)",
                     n_exc, n_ertn, n_write, n_br_kill, n_flush_kill);
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: compile.f
design/csr_pkg.sv
design/pipe_pkg.sv
design/csr_pipe_reg.sv
design/csr_exc_select.sv
design/csr_file.sv
design/csr_unit_top.sv
bench/csr_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       := csr_unit_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# The testbench ends every failing run with $fatal, so the binary exits nonzero
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
